/* Makefile */
.PHONY: help test clean

help:
	@echo "make test   build the testbench with Verilator and run it"
	@echo "make clean  remove the build directory"

test:
	verilator --binary --timing --timescale 1ns/1ns --top-module datapath_tb \
		-f flist.f -Mdir obj_dir -o datapath_tb
	./obj_dir/datapath_tb

clean:
	rm -rf obj_dir

/* design/cpu_types_pkg.sv */
package cpu_types_pkg;

  // basic widths of the 32-bit MIPS subset
  typedef logic [31:0] word_t;
  typedef logic [4:0]  regbits_t;
  typedef logic [4:0]  shamt_t;
  typedef logic [15:0] imm_t;
  typedef logic [25:0] jaddr_t;

  // JAL return address lands here
  parameter regbits_t LINK_REG = 5'd31;

  // primary opcodes
  typedef enum logic [5:0] {
    RTYPE = 6'h00,
    J     = 6'h02,
    JAL   = 6'h03,
    BEQ   = 6'h04,
    BNE   = 6'h05,
    ADDIU = 6'h09,
    ORI   = 6'h0D,
    LUI   = 6'h0F,
    LW    = 6'h23,
    SW    = 6'h2B,
    HALT  = 6'h3F
  } opcode_t;

  // function field of RTYPE
  typedef enum logic [5:0] {
    SLL  = 6'h00,
    ADDU = 6'h21,
    SUBU = 6'h23,
    AND  = 6'h24,
    OR   = 6'h25,
    XOR  = 6'h26,
    SLT  = 6'h2A
  } funct_t;

  // register format
  typedef struct packed {
    opcode_t  opcode;
    regbits_t rs;
    regbits_t rt;
    regbits_t rd;
    shamt_t   shamt;
    funct_t   funct;
  } r_t;

  // immediate format
  typedef struct packed {
    opcode_t  opcode;
    regbits_t rs;
    regbits_t rt;
    imm_t     imm;
  } i_t;

  // jump format
  typedef struct packed {
    opcode_t opcode;
    jaddr_t  addr;
  } j_t;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_SLL
  } aluop_t;

endpackage

/* design/datapath.sv */
module datapath
  import cpu_types_pkg::*, pipe_types_pkg::*;
#(
  parameter word_t PC_INIT = '0
)
(
  input  logic      CLK,
  input  logic      nRST,
  output word_t     imemaddr,
  input  word_t     imemload,
  input  logic      ihit,
  output dmem_req_t dmem_req,
  input  word_t     dmemload,
  input  logic      dhit,
  output logic      halt
);

  fd_t   fd;
  de_t   de;
  de_t   de_next;
  em_t   em;
  em_t   em_next;
  mw_t   mw;
  r_t    fd_instr;
  word_t pc;
  word_t fwd_a;
  word_t fwd_b;
  word_t wb_value;
  logic  mem_wait;
  logic  insert_nop;
  logic  flush;
  logic  stop;
  logic  pc_en;

  // halt in the memory latch or already raised
  assign stop = em.halt || halt;

  // outstanding data request without dhit
  assign mem_wait = (dmem_req.ren || dmem_req.wen) && !dhit;

  assign pc_en = ihit && !insert_nop && !mem_wait && !stop;

  fetch_stage #(
    .PC_INIT (PC_INIT)
  ) fetch (
    .CLK      (CLK),
    .nRST     (nRST),
    .enable   (pc_en),
    .redirect (flush),
    .target   (em.target),
    .pc       (pc)
  );

  assign imemaddr = pc;

  // fetch latch, an ihit miss leaves a bubble
  always_ff @(posedge CLK, negedge nRST)
  begin
    if (!nRST)
      fd <= '0;
    else if (flush || stop)
      fd <= '0;
    else if (mem_wait || insert_nop)
      fd <= fd;
    else if (!ihit)
      fd <= '0;
    else
    begin
      fd.pc <= pc;
      fd.instr <= imemload;
      fd.valid <= 1'b1;
    end
  end

  decode_stage decode (
    .CLK  (CLK),
    .nRST (nRST),
    .fd   (fd),
    .wsel (mw.wsel),
    .wdat (wb_value),
    .wen  (mw.RegWr),
    .de   (de_next)
  );

  assign fd_instr = fd.instr;

  hazard_unit hazard (
    .fd_rs      (fd_instr.rs),
    .fd_rt      (fd_instr.rt),
    .ex_MemRd   (de.MemRd),
    .ex_wsel    (de.wsel),
    .redirect   (em.redirect),
    .insert_nop (insert_nop),
    .flush      (flush)
  );

  // decode latch, load-use bubble goes in here
  always_ff @(posedge CLK, negedge nRST)
  begin
    if (!nRST)
      de <= '0;
    else if (flush || stop)
      de <= '0;
    else if (mem_wait)
      de <= de;
    else if (insert_nop)
      de <= '0;
    else
      de <= de_next;
  end

  forwarding_unit forward (
    .rs         (de.rs),
    .rt         (de.rt),
    .rdat1      (de.rdat1),
    .rdat2      (de.rdat2),
    .mem_wsel   (em.wsel),
    .mem_RegWr  (em.RegWr),
    .mem_aluOut (em.aluOut),
    .wb_wsel    (mw.wsel),
    .wb_RegWr   (mw.RegWr),
    .wb_value   (wb_value),
    .fwd_a      (fwd_a),
    .fwd_b      (fwd_b)
  );

  exec_stage exec (
    .de    (de),
    .fwd_a (fwd_a),
    .fwd_b (fwd_b),
    .em    (em_next)
  );

  // execute latch, also drops the redirecting branch itself
  always_ff @(posedge CLK, negedge nRST)
  begin
    if (!nRST)
      em <= '0;
    else if (flush || stop)
      em <= '0;
    else if (!mem_wait)
      em <= em_next;
  end

  // memory stage, request straight off the latch
  assign dmem_req.ren = em.MemRd;
  assign dmem_req.wen = em.MemWr;
  assign dmem_req.addr = em.aluOut;
  assign dmem_req.store = em.store;

  // memory latch, load data captured on dhit
  always_ff @(posedge CLK, negedge nRST)
  begin
    if (!nRST)
      mw <= '0;
    else if (!mem_wait)
    begin
      mw.pc <= em.pc;
      mw.aluOut <= em.aluOut;
      mw.dmemload <= dmemload;
      mw.wsel <= em.wsel;
      mw.RegWr <= em.RegWr;
      mw.MemToReg <= em.MemToReg;
      mw.WrLinkReg <= em.WrLinkReg;
    end
  end

  // write-back select
  always_comb
  begin
    if (mw.WrLinkReg)
      wb_value = mw.pc + 32'd4;
    else if (mw.MemToReg)
      wb_value = mw.dmemload;
    else
      wb_value = mw.aluOut;
  end

  // sticky until reset
  always_ff @(posedge CLK, negedge nRST)
  begin
    if (!nRST)
      halt <= 1'b0;
    else if (em.halt)
      halt <= 1'b1;
  end

endmodule

/* design/decode_stage.sv */
module decode_stage
  import cpu_types_pkg::*, pipe_types_pkg::*;
(
  input  logic     CLK,
  input  logic     nRST,
  input  fd_t      fd,
  input  regbits_t wsel,
  input  word_t    wdat,
  input  logic     wen,
  output de_t      de
);

  r_t       rinstr;
  i_t       iinstr;
  j_t       jinstr;
  regbits_t rs_sel;
  word_t    rdat1;
  word_t    rdat2;
  logic     legal;

  // one word seen through each format
  assign rinstr = fd.instr;
  assign iinstr = fd.instr;
  assign jinstr = fd.instr;

  // LUI reads r0 so the add in execute passes the immediate
  assign rs_sel = (iinstr.opcode == LUI) ? '0 : rinstr.rs;

  register_file rf (
    .CLK   (CLK),
    .nRST  (nRST),
    .wen   (wen),
    .wsel  (wsel),
    .wdat  (wdat),
    .rsel1 (rs_sel),
    .rsel2 (rinstr.rt),
    .rdat1 (rdat1),
    .rdat2 (rdat2)
  );

  always_comb
  begin
    de = '0;
    legal = 1'b1;
    de.pc = fd.pc;
    de.rdat1 = rdat1;
    de.rdat2 = rdat2;
    de.rs = rs_sel;
    de.rt = rinstr.rt;
    de.shamt = rinstr.shamt;
    // sign extension by default
    de.imm = {{16{iinstr.imm[15]}}, iinstr.imm};
    de.aluop = ALU_ADD;
    case (iinstr.opcode)
      RTYPE:
      begin
        de.wsel = rinstr.rd;
        de.RegWr = 1'b1;
        case (rinstr.funct)
          ADDU: de.aluop = ALU_ADD;
          SUBU: de.aluop = ALU_SUB;
          AND: de.aluop = ALU_AND;
          OR: de.aluop = ALU_OR;
          XOR: de.aluop = ALU_XOR;
          SLT: de.aluop = ALU_SLT;
          SLL: de.aluop = ALU_SLL;
          default: legal = 1'b0;
        endcase
      end
      ADDIU:
      begin
        de.wsel = iinstr.rt;
        de.RegWr = 1'b1;
        de.alusrc = 1'b1;
      end
      ORI:
      begin
        de.wsel = iinstr.rt;
        de.RegWr = 1'b1;
        de.alusrc = 1'b1;
        de.aluop = ALU_OR;
        de.imm = {16'h0000, iinstr.imm};
      end
      LUI:
      begin
        de.wsel = iinstr.rt;
        de.RegWr = 1'b1;
        de.alusrc = 1'b1;
        de.imm = {iinstr.imm, 16'h0000};
      end
      LW:
      begin
        de.wsel = iinstr.rt;
        de.RegWr = 1'b1;
        de.alusrc = 1'b1;
        de.MemRd = 1'b1;
        de.MemToReg = 1'b1;
      end
      SW:
      begin
        de.alusrc = 1'b1;
        de.MemWr = 1'b1;
      end
      BEQ: de.branch = 1'b1;
      BNE:
      begin
        de.branch = 1'b1;
        de.bne = 1'b1;
      end
      J:
      begin
        de.jump = 1'b1;
        de.imm = {6'b000000, jinstr.addr};
      end
      JAL:
      begin
        de.jump = 1'b1;
        de.imm = {6'b000000, jinstr.addr};
        de.wsel = LINK_REG;
        de.RegWr = 1'b1;
        de.WrLinkReg = 1'b1;
      end
      HALT: de.halt = 1'b1;
      default: legal = 1'b0;
    endcase
    // empty slot or unknown encoding
    if (!fd.valid || !legal)
      de = '0;
  end

endmodule

/* design/exec_stage.sv */
module exec_stage
  import cpu_types_pkg::*, pipe_types_pkg::*;
(
  input  de_t   de,
  input  word_t fwd_a,
  input  word_t fwd_b,
  output em_t   em
);

  word_t alu_b;
  word_t alu_out;
  word_t pc_plus4;
  logic  equal;
  logic  taken;

  assign pc_plus4 = de.pc + 32'd4;
  // immediate replaces rt for I-type and memory ops
  assign alu_b = de.alusrc ? de.imm : fwd_b;

  always_comb
  begin
    case (de.aluop)
      ALU_ADD: alu_out = fwd_a + alu_b;
      ALU_SUB: alu_out = fwd_a - alu_b;
      ALU_AND: alu_out = fwd_a & alu_b;
      ALU_OR: alu_out = fwd_a | alu_b;
      ALU_XOR: alu_out = fwd_a ^ alu_b;
      ALU_SLT: alu_out = {31'b0, $signed(fwd_a) < $signed(alu_b)};
      // shifts rt, rs is unused
      ALU_SLL: alu_out = alu_b << de.shamt;
      default: alu_out = '0;
    endcase
  end

  // branch compare on the forwarded registers
  assign equal = (fwd_a == fwd_b);
  assign taken = de.branch && (de.bne ? !equal : equal);

  always_comb
  begin
    em.pc = de.pc;
    // link value so a forward from memory sees pc plus 4
    em.aluOut = de.WrLinkReg ? pc_plus4 : alu_out;
    em.store = fwd_b;
    em.wsel = de.wsel;
    em.RegWr = de.RegWr;
    em.MemRd = de.MemRd;
    em.MemWr = de.MemWr;
    em.MemToReg = de.MemToReg;
    em.WrLinkReg = de.WrLinkReg;
    em.halt = de.halt;
    em.redirect = taken || de.jump;
    if (de.jump)
      em.target = {pc_plus4[31:28], de.imm[25:0], 2'b00};
    else
      em.target = pc_plus4 + {de.imm[29:0], 2'b00};
  end

endmodule

/* design/fetch_stage.sv */
module fetch_stage
  import cpu_types_pkg::*;
#(
  parameter word_t PC_INIT = '0
)
(
  input  logic  CLK,
  input  logic  nRST,
  input  logic  enable,
  input  logic  redirect,
  input  word_t target,
  output word_t pc
);

  // redirect beats a stall, a taken branch never waits on memory
  always_ff @(posedge CLK, negedge nRST)
  begin
    if (!nRST)
      pc <= PC_INIT;
    else if (redirect)
      pc <= target;
    else if (enable)
      pc <= pc + 32'd4;
  end

endmodule

/* design/forwarding_unit.sv */
module forwarding_unit
  import cpu_types_pkg::*;
(
  input  regbits_t rs,
  input  regbits_t rt,
  input  word_t    rdat1,
  input  word_t    rdat2,
  input  regbits_t mem_wsel,
  input  logic     mem_RegWr,
  input  word_t    mem_aluOut,
  input  regbits_t wb_wsel,
  input  logic     wb_RegWr,
  input  word_t    wb_value,
  output word_t    fwd_a,
  output word_t    fwd_b
);

  // youngest producer wins, r0 never overridden
  function automatic word_t pick(regbits_t src, word_t rdat);
    if (src == '0)
      return rdat;
    else if (mem_RegWr && mem_wsel == src)
      return mem_aluOut;
    else if (wb_RegWr && wb_wsel == src)
      return wb_value;
    else
      return rdat;
  endfunction

  always_comb
  begin
    fwd_a = pick(rs, rdat1);
    fwd_b = pick(rt, rdat2);
  end

endmodule

/* design/hazard_unit.sv */
module hazard_unit
  import cpu_types_pkg::*;
(
  input  regbits_t fd_rs,
  input  regbits_t fd_rt,
  input  logic     ex_MemRd,
  input  regbits_t ex_wsel,
  input  logic     redirect,
  output logic     insert_nop,
  output logic     flush
);

  // load in execute feeding the instruction in decode
  // rt compared even when it is a destination, costs a spare bubble at most
  assign insert_nop = ex_MemRd && (ex_wsel != '0) &&
                      ((ex_wsel == fd_rs) || (ex_wsel == fd_rt));

  // taken branch or jump sitting in the memory latch
  assign flush = redirect;

endmodule

/* design/pipe_types_pkg.sv */
package pipe_types_pkg;
  import cpu_types_pkg::*;

  // fetch to decode, all zero is a bubble
  typedef struct packed {
    word_t pc;
    word_t instr;
    logic  valid;
  } fd_t;

  // decode to execute
  typedef struct packed {
    word_t    pc;
    word_t    rdat1;
    word_t    rdat2;
    // extended immediate, or jump index for J and JAL
    word_t    imm;
    regbits_t rs;
    regbits_t rt;
    regbits_t wsel;
    aluop_t   aluop;
    logic     alusrc;
    shamt_t   shamt;
    logic     RegWr;
    logic     MemRd;
    logic     MemWr;
    logic     MemToReg;
    logic     WrLinkReg;
    logic     branch;
    logic     bne;
    logic     jump;
    logic     halt;
  } de_t;

  // execute to memory
  typedef struct packed {
    word_t    pc;
    word_t    aluOut;
    word_t    store;
    regbits_t wsel;
    logic     RegWr;
    logic     MemRd;
    logic     MemWr;
    logic     MemToReg;
    logic     WrLinkReg;
    logic     halt;
    logic     redirect;
    word_t    target;
  } em_t;

  // memory to write-back
  typedef struct packed {
    word_t    pc;
    word_t    aluOut;
    word_t    dmemload;
    regbits_t wsel;
    logic     RegWr;
    logic     MemToReg;
    logic     WrLinkReg;
  } mw_t;

  // data memory request
  typedef struct packed {
    logic  ren;
    logic  wen;
    word_t addr;
    word_t store;
  } dmem_req_t;

endpackage

/* design/register_file.sv */
module register_file
  import cpu_types_pkg::*;
(
  input  logic     CLK,
  input  logic     nRST,
  input  logic     wen,
  input  regbits_t wsel,
  input  word_t    wdat,
  input  regbits_t rsel1,
  input  regbits_t rsel2,
  output word_t    rdat1,
  output word_t    rdat2
);

  // register 0 has no storage
  word_t regs [1:31];

  // zero, then same-cycle write data, then stored value
  function automatic word_t read_port(regbits_t sel);
    if (sel == '0)
      return '0;
    else if (wen && sel == wsel)
      return wdat;
    else
      return regs[sel];
  endfunction

  always_ff @(posedge CLK, negedge nRST)
  begin
    if (!nRST)
      regs <= '{default: '0};
    else if (wen && wsel != '0)
      regs[wsel] <= wdat;
  end

  always_comb
  begin
    rdat1 = read_port(rsel1);
    rdat2 = read_port(rsel2);
  end

endmodule

/* flist.f */
design/cpu_types_pkg.sv
design/pipe_types_pkg.sv
design/register_file.sv
design/fetch_stage.sv
design/decode_stage.sv
design/exec_stage.sv
design/forwarding_unit.sv
design/hazard_unit.sv
design/datapath.sv
sim/datapath_tb.sv

/* sim/datapath_tb.sv */
module datapath_tb
  import cpu_types_pkg::*, pipe_types_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ns;

  logic      CLK = 1'b0;
  logic      nRST = 1'b0;
  logic      ihit = 1'b0;
  logic      dhit = 1'b0;
  word_t     imemaddr;
  word_t     imemload;
  word_t     dmemload;
  dmem_req_t dmem_req;
  logic      halt;

  // both memories word addressed through bits 9:2
  word_t imem [256] = '{default: '0};
  word_t dmem [256] = '{default: '0};

  // program words and the store sequence it has to produce
  word_t prog [$];
  word_t exp_addr [$];
  word_t exp_data [$];

  word_t rng_state = 32'd63864;
  logic  waits_on = 1'b0;
  int    stores_seen = 0;
  int    cycles = 0;
  int    cycle_limit = 0;

  always #20 CLK = ~CLK;

  datapath #(
    .PC_INIT (32'h0000_0000)
  ) dut (
    .CLK      (CLK),
    .nRST     (nRST),
    .imemaddr (imemaddr),
    .imemload (imemload),
    .ihit     (ihit),
    .dmem_req (dmem_req),
    .dmemload (dmemload),
    .dhit     (dhit),
    .halt     (halt)
  );

  // asynchronous array reads
  assign imemload = imem[imemaddr[9:2]];
  assign dmemload = dmem[dmem_req.addr[9:2]];

  function automatic word_t rtype_word(funct_t f, regbits_t rd, regbits_t rs, regbits_t rt,
                                       shamt_t sh);
    return {6'h00, rs, rt, rd, sh, f};
  endfunction

  // rt is the destination or store source
  function automatic word_t itype_word(opcode_t op, regbits_t rt, regbits_t rs, imm_t imm);
    return {op, rs, rt, imm};
  endfunction

  function automatic word_t jump_word(opcode_t op, jaddr_t index);
    return {op, index};
  endfunction

  function automatic word_t xorshift(word_t x);
    word_t y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // about one cycle in four withheld when wait states are on
  function automatic logic next_hit();
    rng_state = xorshift(rng_state);
    return !waits_on || (rng_state[1:0] != 2'b00);
  endfunction

  task automatic check_word(string name, word_t got, word_t exp);
    if (got !== exp)
    begin
      $display("[ERROR] t=%0t %s: got %h, expected %h", $time, name, got, exp);
      $display("Test failed");
      $fatal(1, "wrong value on %s", name);
    end
  endtask

  task automatic check_bit(string name, logic got, logic exp);
    if (got !== exp)
    begin
      $display("[ERROR] t=%0t %s: got %b, expected %b", $time, name, got, exp);
      $display("Test failed");
      $fatal(1, "wrong level on %s", name);
    end
  endtask

  task automatic expect_store(word_t addr, word_t data);
    exp_addr.push_back(addr);
    exp_data.push_back(data);
  endtask

  task automatic build_program();
    // 0..11 dependent ALU chain with r10 as the store base
    prog.push_back(itype_word(ADDIU, 5'd10, 5'd0, 16'h0100));
    prog.push_back(itype_word(ADDIU, 5'd1, 5'd0, 16'h0123));
    prog.push_back(itype_word(ADDIU, 5'd2, 5'd0, 16'hFFFB));
    prog.push_back(rtype_word(ADDU, 5'd3, 5'd1, 5'd2, 5'd0));
    prog.push_back(itype_word(SW, 5'd3, 5'd10, 16'h0000));
    prog.push_back(rtype_word(SUBU, 5'd4, 5'd1, 5'd3, 5'd0));
    prog.push_back(itype_word(LUI, 5'd5, 5'd0, 16'h8000));
    prog.push_back(itype_word(ORI, 5'd5, 5'd5, 16'h00F0));
    prog.push_back(rtype_word(AND, 5'd6, 5'd5, 5'd3, 5'd0));
    prog.push_back(rtype_word(XOR, 5'd7, 5'd6, 5'd4, 5'd0));
    prog.push_back(rtype_word(SLT, 5'd8, 5'd5, 5'd4, 5'd0));
    prog.push_back(rtype_word(SLL, 5'd9, 5'd0, 5'd7, 5'd4));
    // 12..17 results out in order
    prog.push_back(itype_word(SW, 5'd4, 5'd10, 16'h0004));
    prog.push_back(itype_word(SW, 5'd5, 5'd10, 16'h0008));
    prog.push_back(itype_word(SW, 5'd6, 5'd10, 16'h000C));
    prog.push_back(itype_word(SW, 5'd7, 5'd10, 16'h0010));
    prog.push_back(itype_word(SW, 5'd8, 5'd10, 16'h0014));
    prog.push_back(itype_word(SW, 5'd9, 5'd10, 16'h0018));
    // 18..22 load-use pairs on rs and on store data
    prog.push_back(itype_word(LW, 5'd11, 5'd0, 16'h0040));
    prog.push_back(rtype_word(ADDU, 5'd12, 5'd11, 5'd1, 5'd0));
    prog.push_back(itype_word(SW, 5'd12, 5'd10, 16'h001C));
    prog.push_back(itype_word(LW, 5'd13, 5'd10, 16'h0000));
    prog.push_back(itype_word(SW, 5'd13, 5'd10, 16'h0020));
    // 23 BEQ not taken and 25 BNE taken to 28
    prog.push_back(itype_word(BEQ, 5'd2, 5'd1, 16'h0003));
    prog.push_back(itype_word(ADDIU, 5'd14, 5'd0, 16'h0077));
    prog.push_back(itype_word(BNE, 5'd1, 5'd14, 16'h0002));
    prog.push_back(itype_word(SW, 5'd0, 5'd0, 16'h0080));
    prog.push_back(itype_word(SW, 5'd0, 5'd0, 16'h0084));
    // 28 BNE not taken and 30 BEQ taken to 33
    prog.push_back(itype_word(BNE, 5'd14, 5'd14, 16'h0002));
    prog.push_back(itype_word(SW, 5'd14, 5'd10, 16'h0024));
    prog.push_back(itype_word(BEQ, 5'd14, 5'd14, 16'h0002));
    prog.push_back(itype_word(SW, 5'd0, 5'd0, 16'h0088));
    prog.push_back(itype_word(SW, 5'd0, 5'd0, 16'h008C));
    // 33 J to 36 and 36 JAL to 39
    prog.push_back(jump_word(J, 26'd36));
    prog.push_back(itype_word(SW, 5'd0, 5'd0, 16'h0090));
    prog.push_back(itype_word(SW, 5'd0, 5'd0, 16'h0094));
    prog.push_back(jump_word(JAL, 26'd39));
    prog.push_back(itype_word(SW, 5'd0, 5'd0, 16'h0098));
    prog.push_back(itype_word(SW, 5'd0, 5'd0, 16'h009C));
    // link value stored and then used once more
    prog.push_back(itype_word(SW, 5'd31, 5'd10, 16'h0028));
    prog.push_back(rtype_word(ADDU, 5'd15, 5'd31, 5'd14, 5'd0));
    prog.push_back(itype_word(SW, 5'd15, 5'd10, 16'h002C));
    prog.push_back(jump_word(HALT, 26'd0));
    // behind HALT so never stored
    prog.push_back(itype_word(SW, 5'd0, 5'd10, 16'h0030));

    // 0x123 + -5 and then 0x123 - 0x11E
    expect_store(32'h0000_0100, 32'h0000_011E);
    expect_store(32'h0000_0104, 32'h0000_0005);
    expect_store(32'h0000_0108, 32'h8000_00F0);
    expect_store(32'h0000_010C, 32'h0000_0010);
    expect_store(32'h0000_0110, 32'h0000_0015);
    // negative r5 below 5
    expect_store(32'h0000_0114, 32'h0000_0001);
    expect_store(32'h0000_0118, 32'h0000_0150);
    // fill word at 0x40 plus 0x123
    expect_store(32'h0000_011C, 32'h600D_0163);
    expect_store(32'h0000_0120, 32'h0000_011E);
    expect_store(32'h0000_0124, 32'h0000_0077);
    // JAL at 0x90
    expect_store(32'h0000_0128, 32'h0000_0094);
    expect_store(32'h0000_012C, 32'h0000_010B);
  endtask

  task automatic take_store(word_t addr, word_t data);
    if (stores_seen >= exp_addr.size())
    begin
      $display("store to %h after the expected sequence had ended", addr);
      $display("Test failed");
      $fatal(1, "extra store");
    end
    else
    begin
      check_word("dmem_req.addr", addr, exp_addr[stores_seen]);
      check_word("dmem_req.store", data, exp_data[stores_seen]);
      stores_seen = stores_seen + 1;
    end
  endtask

  // memory model sees requests as they stood before the edge
  always @(posedge CLK)
  begin
    if (!nRST)
    begin
      // reload each pass with a data fill that carries its own address
      for (int i = 0; i < 256; i++)
      begin
        imem[i] <= (i < prog.size()) ? prog[i] : '0;
        dmem[i] <= {16'h600D, 6'b000000, i[7:0], 2'b00};
      end
      stores_seen = 0;
      ihit <= 1'b0;
      dhit <= 1'b0;
    end
    else
    begin
      // program opens with a store so no read may come first
      if (stores_seen == 0)
        check_bit("dmem_req.ren", dmem_req.ren, 1'b0);
      if (dmem_req.wen && dhit)
      begin
        dmem[dmem_req.addr[9:2]] <= dmem_req.store;
        take_store(dmem_req.addr, dmem_req.store);
      end
      ihit <= next_hit();
      dhit <= next_hit();
    end
  end

  // run limit over both passes
  always @(posedge CLK)
  begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit)
    begin
      $display("run did not finish within %0d cycles", cycle_limit);
      $display("Test failed");
      $fatal(1, "timeout");
    end
  end

  task automatic run_pass(input logic with_waits);
    @(posedge CLK);
    nRST <= 1'b0;
    waits_on <= with_waits;
    repeat (2) @(posedge CLK);
    nRST <= 1'b1;
    @(posedge CLK);
    // state left by reset
    check_bit("halt", halt, 1'b0);
    check_word("imemaddr", imemaddr, 32'h0000_0000);
    check_bit("dmem_req.wen", dmem_req.wen, 1'b0);
    while (halt !== 1'b1)
      @(posedge CLK);
    // halted core stays quiet
    repeat (20)
    begin
      @(posedge CLK);
      check_bit("halt", halt, 1'b1);
      check_bit("dmem_req.wen", dmem_req.wen, 1'b0);
      check_bit("dmem_req.ren", dmem_req.ren, 1'b0);
    end
    if (stores_seen != exp_addr.size())
    begin
      $display("halted after %0d of %0d expected stores", stores_seen, exp_addr.size());
      $display("Test failed");
      $fatal(1, "missing store");
    end
  endtask

  initial
  begin
    build_program();
    cycle_limit = prog.size() * 8 * 2;
    // first pass without wait states and second with random ones
    for (int pass = 0; pass < 2; pass++)
      run_pass(pass == 1);
    $display("Test passed");
    $finish;
  end

endmodule
